// File: source/lsu_config.svh
/*
 * width defines for the load/store unit and its data bus
 */

`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// core address and bus address width
`define LSU_ADDR_W 32

`define LSU_DATA_W 32 // bus data, one word

// one enable per byte lane
`define LSU_BE_W 4

`define LSU_OFS_W 2 // byte offset inside a word

`endif

// File: source/lsu_pkg.sv
/*
 * core-side types: access size, FSM states, core request
 */

`default_nettype none

`include "lsu_config.svh"

package lsu_pkg;

  // 2'b11 is not listed, decoders treat it as a byte like 2'b10
  typedef enum logic [1:0] {
    size_word = 2'b00,
    size_half = 2'b01,
    size_byte = 2'b10
  } mem_size_e;

  typedef enum logic [2:0] {
    st_idle,                     // no access in flight
    st_wait_gnt_mis,             // split access, first grant pending
    st_wait_rvalid_mis,          // first part granted, second part requested
    st_wait_gnt,                 // aligned access or second part waits for grant
    st_wait_rvalid_mis_gnts_done // both granted, first rvalid pending
  } ls_state_e;

  typedef struct packed {
    logic                   we;       // store when set
    mem_size_e              size;
    logic                   sign_ext; // loads only
    logic [`LSU_ADDR_W-1:0] addr;     // byte address from the ALU
    logic [`LSU_DATA_W-1:0] wdata;    // store data, right aligned
  } lsu_req_t;

endpackage

`default_nettype wire

// File: source/lsu_bus_pkg.sv
/*
 * data bus types: outgoing request and incoming response
 */

`default_nettype none

`include "lsu_config.svh"

package lsu_bus_pkg;

  typedef struct packed {
    logic [`LSU_ADDR_W-1:0] addr;  // always word aligned
    logic                   we;
    logic [`LSU_BE_W-1:0]   be;
    logic [`LSU_DATA_W-1:0] wdata; // already rotated onto lanes
  } bus_req_t;

  typedef struct packed {
    logic                   gnt;    // address phase accepted
    logic                   rvalid; // one per accepted request, in order
    logic                   err;    // valid with rvalid
    logic [`LSU_DATA_W-1:0] rdata;
  } bus_rsp_t;

endpackage

`default_nettype wire

// File: source/lsu_wdata_align.sv
/*
 * byte-enable generation and store data rotation for one bus transaction
 */

`default_nettype none

`include "lsu_config.svh"

module lsu_wdata_align import lsu_pkg::*; (
  input  lsu_req_t               req_i,
  input  logic                   second_part_i, // spill-over part of a split access
  output logic [`LSU_BE_W-1:0]   be_o,
  output logic [`LSU_DATA_W-1:0] wdata_o
);

  logic [`LSU_OFS_W-1:0] ofs;

  assign ofs = req_i.addr[`LSU_OFS_W-1:0];

  // lanes touched by this transaction
  always_comb begin
    case (req_i.size)
      size_word: begin
        if (!second_part_i) be_o = 4'b1111 << ofs;   // from offset up to lane 3
        else                be_o = ~(4'b1111 << ofs); // the bytes that spilled over
      end
      size_half: begin
        if (!second_part_i) be_o = 4'b0011 << ofs;   // offset 3 keeps lane 3 only
        else                be_o = 4'b0001;          // top byte of a half at offset 3
      end
      default: be_o = 4'b0001 << ofs; // bytes, both encodings
    endcase
  end

  // rotate left by the offset so byte 0 of the data sits on lane ofs,
  // bytes pushed past lane 3 wrap to the low lanes for the second part
  always_comb begin
    case (ofs)
      2'b01:   wdata_o = {req_i.wdata[23:0], req_i.wdata[31:24]};
      2'b10:   wdata_o = {req_i.wdata[15:0], req_i.wdata[31:16]};
      2'b11:   wdata_o = {req_i.wdata[7:0], req_i.wdata[31:8]};
      default: wdata_o = req_i.wdata;
    endcase
  end

endmodule

`default_nettype wire

// File: source/lsu_rdata_align.sv
/*
 * transaction control registers, partial word register,
 * read data realignment with zero or sign extension
 */

`default_nettype none

`include "lsu_config.svh"

module lsu_rdata_align import lsu_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   ctrl_update_i,  // a part of the access was accepted
  input  logic                   rdata_update_i, // first response of a split load
  input  lsu_req_t               req_i,
  input  logic [`LSU_DATA_W-1:0] rdata_i,
  output logic [`LSU_DATA_W-1:0] rdata_o,
  output logic                   we_q_o
);

  logic [`LSU_OFS_W-1:0]   ofs_q;
  mem_size_e               size_q;
  logic                    sign_ext_q;
  logic                    we_q;
  logic [`LSU_DATA_W-1:8]  rdata_q;  // upper three bytes of the first word

  logic [`LSU_DATA_W-1:0]  rdata_shift; // response moved down by the offset
  logic [`LSU_DATA_W-1:0]  rdata_w;
  logic [15:0]             rdata_h;
  logic [7:0]              rdata_b;

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ofs_q      <= '0;
      size_q     <= size_word;
      sign_ext_q <= 1'b0;
      we_q       <= 1'b0;
    end else if (ctrl_update_i) begin
      ofs_q      <= req_i.addr[`LSU_OFS_W-1:0];
      size_q     <= req_i.size;
      sign_ext_q <= req_i.sign_ext;
      we_q       <= req_i.we;
    end
  end

  // only meaningful between the two responses of a split load
  always_ff @(posedge clk_i) begin
    if (rdata_update_i) begin
      rdata_q <= rdata_i[`LSU_DATA_W-1:8];
    end
  end

  ////////////////////////////////////////////////////////////
  // realignment
  ////////////////////////////////////////////////////////////

  // accesses that fit in one word only need a shift
  assign rdata_shift = rdata_i >> {ofs_q, 3'b000};

  // words, low part from the held first response when split
  always_comb begin
    case (ofs_q)
      2'b01:   rdata_w = {rdata_i[7:0], rdata_q[31:8]};
      2'b10:   rdata_w = {rdata_i[15:0], rdata_q[31:16]};
      2'b11:   rdata_w = {rdata_i[23:0], rdata_q[31:24]};
      default: rdata_w = rdata_i;
    endcase
  end

  // half at offset 3 is the only split half
  assign rdata_h = (ofs_q == 2'b11) ? {rdata_i[7:0], rdata_q[31:24]} : rdata_shift[15:0];
  assign rdata_b = rdata_shift[7:0];

  // extension, the sign bit counts only when the flag is set
  always_comb begin
    case (size_q)
      size_word: rdata_o = rdata_w;
      size_half: rdata_o = {{16{sign_ext_q & rdata_h[15]}}, rdata_h};
      default:   rdata_o = {{24{sign_ext_q & rdata_b[7]}}, rdata_b};
    endcase
  end

  assign we_q_o = we_q; // direction of the access in flight

endmodule

`default_nettype wire

// File: source/lsu_ctrl_fsm.sv
/*
 * bus transaction FSM with split-access handling, error tracking,
 * last-address register and status strobes
 */

`default_nettype none

`include "lsu_config.svh"

module lsu_ctrl_fsm import lsu_pkg::*, lsu_bus_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   lsu_req_i,
  input  lsu_req_t               req_i,
  input  bus_rsp_t               rsp_i,
  input  logic                   pmp_err_i,   // address phase only
  input  logic                   data_we_q_i, // direction held at the last accept
  output logic                   bus_req_o,
  output logic                   second_part_o,
  output logic                   addr_incr_req_o,
  output logic [`LSU_ADDR_W-1:0] addr_last_o,
  output logic                   ctrl_update_o,
  output logic                   rdata_update_o,
  output logic                   req_done_o,
  output logic                   resp_valid_o,
  output logic                   rdata_valid_o,
  output logic                   load_err_o,
  output logic                   store_err_o,
  output logic                   busy_o,
  output logic                   perf_load_o,
  output logic                   perf_store_o
);

  ls_state_e              state_q, state_d;
  logic                   handle_mis_q, handle_mis_d; // first part of a split access granted
  logic                   pmp_err_q, pmp_err_d;
  logic                   lsu_err_q, lsu_err_d;       // first part of a split access failed
  logic [`LSU_ADDR_W-1:0] addr_last_q, addr_last_d;
  logic                   addr_update;
  logic                   split_access;
  logic                   go;                         // new request taken in idle
  logic                   err_any;
  logic [`LSU_OFS_W-1:0]  ofs;

  assign ofs = req_i.addr[`LSU_OFS_W-1:0];

  // needs two word-aligned bus transactions
  assign split_access = ((req_i.size == size_word) && (ofs != 2'b00)) ||
                        ((req_i.size == size_half) && (ofs == 2'b11));

  ////////////////////////////////////////////////////////////
  // next state and strobes
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    handle_mis_d    = handle_mis_q;
    pmp_err_d       = pmp_err_q;
    lsu_err_d       = lsu_err_q;
    bus_req_o       = 1'b0;
    addr_incr_req_o = 1'b0;
    addr_update     = 1'b0;
    ctrl_update_o   = 1'b0;
    rdata_update_o  = 1'b0;
    perf_load_o     = 1'b0;
    perf_store_o    = 1'b0;
    go              = 1'b0;

    case (state_q)
      st_idle: begin
        pmp_err_d = 1'b0;
        if (lsu_req_i) begin
          bus_req_o    = 1'b1;
          pmp_err_d    = pmp_err_i;
          lsu_err_d    = 1'b0;
          perf_load_o  = ~req_i.we;
          perf_store_o = req_i.we;
          go           = 1'b1;
          // a pmp error stands in for the grant
          if (rsp_i.gnt || pmp_err_i) begin
            ctrl_update_o = 1'b1;
            addr_update   = 1'b1;
            handle_mis_d  = split_access;
            state_d       = split_access ? st_wait_rvalid_mis : st_idle;
          end else begin
            state_d = split_access ? st_wait_gnt_mis : st_wait_gnt;
          end
        end
      end

      st_wait_gnt_mis: begin
        bus_req_o = 1'b1; // request held, core keeps the data stable
        if (rsp_i.gnt || pmp_err_q) begin
          ctrl_update_o = 1'b1;
          addr_update   = 1'b1;
          handle_mis_d  = 1'b1;
          state_d       = st_wait_rvalid_mis;
        end
      end

      st_wait_rvalid_mis: begin
        bus_req_o       = 1'b1; // second part goes out right away
        addr_incr_req_o = 1'b1;
        if (rsp_i.rvalid || pmp_err_q) begin
          pmp_err_d      = pmp_err_i;               // now for the second part
          lsu_err_d      = rsp_i.err | pmp_err_q;   // outcome of the first part
          rdata_update_o = ~data_we_q_i;
          state_d        = rsp_i.gnt ? st_idle : st_wait_gnt;
          addr_update    = rsp_i.gnt & ~(rsp_i.err | pmp_err_q);
          handle_mis_d   = ~rsp_i.gnt;
        end else if (rsp_i.gnt) begin
          state_d      = st_wait_rvalid_mis_gnts_done; // second grant overtook rvalid
          handle_mis_d = 1'b0;
        end
      end

      st_wait_gnt: begin
        bus_req_o       = 1'b1;
        addr_incr_req_o = handle_mis_q; // set only for the second part
        if (rsp_i.gnt || pmp_err_q) begin
          ctrl_update_o = 1'b1;
          addr_update   = ~lsu_err_q; // keep the first failing address
          handle_mis_d  = 1'b0;
          state_d       = st_idle;
        end
      end

      st_wait_rvalid_mis_gnts_done: begin
        addr_incr_req_o = 1'b1; // second address still needed for addr_last
        if (rsp_i.rvalid) begin
          pmp_err_d      = pmp_err_i;
          lsu_err_d      = rsp_i.err; // first part was granted, so no pmp error
          addr_update    = ~rsp_i.err;
          rdata_update_o = ~data_we_q_i;
          state_d        = st_idle;
        end
      end

      default: state_d = st_idle;
    endcase
  end

  // first part reports the byte address, the second one the word address
  assign addr_last_d = addr_incr_req_o ? {req_i.addr[`LSU_ADDR_W-1:2], 2'b00} : req_i.addr;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= st_idle;
      handle_mis_q <= 1'b0;
      pmp_err_q    <= 1'b0;
      lsu_err_q    <= 1'b0;
      addr_last_q  <= '0;
    end else begin
      state_q      <= state_d;
      handle_mis_q <= handle_mis_d;
      pmp_err_q    <= pmp_err_d;
      lsu_err_q    <= lsu_err_d;
      if (addr_update) addr_last_q <= addr_last_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////

  assign err_any = lsu_err_q | rsp_i.err | pmp_err_q;

  // done once the last part is accepted, data follows later
  assign req_done_o    = (go | (state_q != st_idle)) & (state_d == st_idle);
  assign resp_valid_o  = (rsp_i.rvalid | pmp_err_q) & (state_q == st_idle);
  assign rdata_valid_o = (state_q == st_idle) & rsp_i.rvalid & ~err_any & ~data_we_q_i;

  assign load_err_o    = err_any & ~data_we_q_i & resp_valid_o;
  assign store_err_o   = err_any & data_we_q_i & resp_valid_o;

  assign second_part_o = handle_mis_q;
  assign addr_last_o   = addr_last_q;
  assign busy_o        = (state_q != st_idle);

endmodule

`default_nettype wire

// File: source/load_store_unit.sv
/*
 * load/store unit top: FSM, store aligner and load aligner,
 * bus request assembly
 */

`default_nettype none

`include "lsu_config.svh"

module load_store_unit import lsu_pkg::*, lsu_bus_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // core request, held until req_done_o
  input  logic                   lsu_req_i,
  input  lsu_req_t               lsu_req_data_i,

  // data bus
  input  bus_rsp_t               bus_rsp_i,
  input  logic                   pmp_err_i,
  output logic                   bus_req_o,
  output bus_req_t               bus_req_data_o,

  // back to the core
  output logic [`LSU_DATA_W-1:0] lsu_rdata_o,
  output logic                   rdata_valid_o,
  output logic                   resp_valid_o,
  output logic                   req_done_o,
  output logic                   addr_incr_req_o,
  output logic [`LSU_ADDR_W-1:0] addr_last_o,
  output logic                   load_err_o,
  output logic                   store_err_o,
  output logic                   busy_o,
  output logic                   perf_load_o,
  output logic                   perf_store_o
);

  lsu_req_t               req_eff;      // request with the offset of the whole access
  logic                   second_part;
  logic                   ctrl_update;
  logic                   rdata_update;
  logic                   data_we_q;
  logic [`LSU_BE_W-1:0]   be;
  logic [`LSU_DATA_W-1:0] wdata;

  // during the second part the core shows the next word address,
  // the original byte offset still sits in addr_last
  always_comb begin
    req_eff = lsu_req_data_i;
    if (second_part) begin
      req_eff.addr[`LSU_OFS_W-1:0] = addr_last_o[`LSU_OFS_W-1:0];
    end
  end

  lsu_ctrl_fsm ctrl_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .lsu_req_i       (lsu_req_i),
    .req_i           (lsu_req_data_i),
    .rsp_i           (bus_rsp_i),
    .pmp_err_i       (pmp_err_i),
    .data_we_q_i     (data_we_q),
    .bus_req_o       (bus_req_o),
    .second_part_o   (second_part),
    .addr_incr_req_o (addr_incr_req_o),
    .addr_last_o     (addr_last_o),
    .ctrl_update_o   (ctrl_update),
    .rdata_update_o  (rdata_update),
    .req_done_o      (req_done_o),
    .resp_valid_o    (resp_valid_o),
    .rdata_valid_o   (rdata_valid_o),
    .load_err_o      (load_err_o),
    .store_err_o     (store_err_o),
    .busy_o          (busy_o),
    .perf_load_o     (perf_load_o),
    .perf_store_o    (perf_store_o)
  );

  lsu_wdata_align wdata_align_i (
    .req_i         (req_eff),
    .second_part_i (second_part),
    .be_o          (be),
    .wdata_o       (wdata)
  );

  lsu_rdata_align rdata_align_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ctrl_update_i  (ctrl_update),
    .rdata_update_i (rdata_update),
    .req_i          (req_eff),
    .rdata_i        (bus_rsp_i.rdata),
    .rdata_o        (lsu_rdata_o),
    .we_q_o         (data_we_q)
  );

  // bus only sees word addresses
  always_comb begin
    bus_req_data_o.addr  = {lsu_req_data_i.addr[`LSU_ADDR_W-1:2], 2'b00};
    bus_req_data_o.we    = lsu_req_data_i.we;
    bus_req_data_o.be    = be;
    bus_req_data_o.wdata = wdata;
  end

endmodule

`default_nettype wire

// File: test/lsu_checker.sv
/*
 * concurrent assertions on bus requests and FSM state, bound into the LSU top level
 */

`default_nettype none

module lsu_checker import lsu_pkg::*, lsu_bus_pkg::*; (
  input logic      clk_i,
  input logic      rst_ni,
  input logic      bus_req_i,
  input bus_req_t  bus_req_data_i,
  input bus_rsp_t  bus_rsp_i,
  input logic      pmp_err_i,
  input logic      req_done_i,
  input logic      resp_valid_i,
  input logic      busy_i,
  input ls_state_e state_i // FSM state register
);

  // only word addresses leave the unit
  a_addr_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_i |-> bus_req_data_i.addr[1:0] == 2'b00)
    else $error("bus address not word aligned");

  a_state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_i inside {st_idle, st_wait_gnt_mis, st_wait_rvalid_mis, st_wait_gnt,
                    st_wait_rvalid_mis_gnts_done})
    else $error("FSM state outside the enum");

  // a pending request keeps its address, enables and data
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_i && !bus_rsp_i.gnt && !pmp_err_i && !req_done_i
      |=> bus_req_i && $stable(bus_req_data_i))
    else $error("bus request changed while waiting for grant");

  a_resp_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_i |-> !busy_i)
    else $error("resp_valid_o while busy");

endmodule

bind load_store_unit lsu_checker checker_i (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .bus_req_i      (bus_req_o),
  .bus_req_data_i (bus_req_data_o),
  .bus_rsp_i      (bus_rsp_i),
  .pmp_err_i      (pmp_err_i),
  .req_done_i     (req_done_o),
  .resp_valid_i   (resp_valid_o),
  .busy_i         (busy_o),
  .state_i        (ctrl_i.state_q)
);

`default_nettype wire

// File: test/lsu_tb.sv
/*
 * LSU testbench: seeded random accesses, byte memory with bus model,
 * reference memory, directed bus and pmp errors
 */

`default_nettype none

module lsu_tb import lsu_pkg::*, lsu_bus_pkg::*; ();

  localparam int          N_RAND = 300;
  localparam int          N_DIR  = 6;
  localparam logic [31:0] BASE   = 32'h0000_4000; // 64-word window

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        lsu_req;
  lsu_req_t    req_data;
  bus_rsp_t    bus_rsp;
  logic        pmp_err;
  logic        bus_req;
  bus_req_t    bus_req_data;
  logic [31:0] rdata;
  logic [31:0] addr_last;
  logic        rdata_valid, resp_valid, req_done, addr_incr;
  logic        load_err, store_err, busy, perf_load, perf_store;

  integer      seed;
  integer      errors;
  integer      n_acc;
  integer      mark;
  integer      k;
  logic [31:0] r;
  logic [7:0]  mem [0:255];     // memory behind the bus
  logic [7:0]  ref_mem [0:255]; // expected contents
  logic        err_word [0:63]; // words that answer with err
  logic [29:0] pmp_word;        // word that trips the pmp
  integer      gnt_wait;        // cycles until the next grant
  logic        rv_next, err_next;
  logic [31:0] rd_next;
  logic        waited;          // last cycle held a request without grant
  integer      n_gnt, n_done;
  logic [3:0]  be_log [0:1];
  logic [31:0] baddr_log [0:1];

  always #4 clk_i = ~clk_i;

  load_store_unit dut_i (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .lsu_req_i (lsu_req), .lsu_req_data_i (req_data),
    .bus_rsp_i (bus_rsp), .pmp_err_i (pmp_err),
    .bus_req_o (bus_req), .bus_req_data_o (bus_req_data),
    .lsu_rdata_o (rdata), .rdata_valid_o (rdata_valid),
    .resp_valid_o (resp_valid), .req_done_o (req_done),
    .addr_incr_req_o (addr_incr), .addr_last_o (addr_last),
    .load_err_o (load_err), .store_err_o (store_err),
    .busy_o (busy), .perf_load_o (perf_load), .perf_store_o (perf_store)
  );

  task automatic flag_error(input string msg);
    errors = errors + 1;
    $display("CHECK FAILED at time %0t: %s", $time, msg);
  endtask

  ////////////////////////////////////////////////////////////
  // bus model
  ////////////////////////////////////////////////////////////

  // sampled at the falling edge, everything settled
  task automatic bus_sample();
    integer     l;
    logic [7:0] w;
    rv_next = 1'b0;
    if (waited && !bus_req) flag_error("bus_req_o dropped before its grant");
    waited = bus_req && !bus_rsp.gnt && !req_done;
    if (bus_req && bus_rsp.gnt) begin
      w = bus_req_data.addr[7:0];
      if (n_gnt < 2) begin
        be_log[n_gnt]    = bus_req_data.be;
        baddr_log[n_gnt] = bus_req_data.addr;
      end
      n_gnt    = n_gnt + 1;
      err_next = err_word[w[7:2]];
      rd_next  = {mem[w + 3], mem[w + 2], mem[w + 1], mem[w]};
      rv_next  = 1'b1; // answer in the next cycle
      for (l = 0; l < 4; l++) begin
        if (bus_req_data.we && bus_req_data.be[l] && !err_next) begin
          mem[w + l] = bus_req_data.wdata[8*l +: 8];
        end
      end
      gnt_wait = $random(seed) & 3;
    end else if (bus_req && gnt_wait > 0) begin
      gnt_wait = gnt_wait - 1;
    end
    if (req_done) n_done = n_done + 1;
    if (req_done && !(bus_req && bus_rsp.gnt) && !pmp_err) flag_error("req_done_o without grant");
  endtask

  task automatic bus_drive();
    bus_rsp.rvalid = rv_next;
    bus_rsp.err    = rv_next & err_next;
    bus_rsp.rdata  = rv_next ? rd_next : $random(seed);
    bus_rsp.gnt    = (gnt_wait == 0) && !pmp_err; // pmp stands in for the grant
  endtask

  ////////////////////////////////////////////////////////////
  // core side, one access with its reference result
  ////////////////////////////////////////////////////////////

  task automatic run_access(input logic we, input logic [1:0] sz, input logic sx,
                            input logic [31:0] addr, input logic [31:0] wd);
    integer      i, n, cyc, mism;
    logic [7:0]  mask, bi;
    logic [31:0] exp_val, last_exp, cur;
    logic        pmp, split, err_exp, resp_seen;
    n        = (sz == 2'b00) ? 4 : (sz == 2'b01) ? 2 : 1; // both byte codes
    mask     = ((8'h01 << n) - 8'h01) << addr[1:0];       // lanes over two words
    split    = (mask[7:4] != 4'h0);
    pmp      = (addr[31:2] == pmp_word);
    err_exp  = pmp || err_word[addr[7:2]] || (split && err_word[addr[7:2] + 6'd1]);
    last_exp = (pmp || err_word[addr[7:2]]) ? addr : {addr[31:2] + 30'd1, 2'b00};
    exp_val  = '0;
    for (i = 0; i < n; i++) begin
      bi = addr[7:0] + i;
      exp_val[8*i +: 8] = ref_mem[bi];
      if (we && !err_exp) ref_mem[bi] = wd[8*i +: 8];
    end
    if (sx && n < 4 && exp_val[8*n-1]) exp_val = exp_val | (32'hffff_ffff << (8 * n));
    n_gnt     = 0;
    n_done    = 0;
    resp_seen = 1'b0;
    for (cyc = 0; cyc < 100 && !resp_seen; cyc++) begin
      @(posedge clk_i);
      #1;
      cur      = addr_incr ? {addr[31:2] + 30'd1, 2'b00} : addr; // next word for part two
      lsu_req  = (n_done == 0);
      req_data = '{we: we, size: mem_size_e'(sz), sign_ext: sx, addr: cur, wdata: wd};
      pmp_err  = lsu_req && (cur[31:2] == pmp_word);
      bus_drive();
      @(negedge clk_i);
      if (cyc == 0 && (perf_load !== ~we || perf_store !== we)) flag_error("perf strobe wrong");
      if (resp_valid) begin
        resp_seen = 1'b1;
        if (busy) flag_error("busy_o high at the response");
        if (load_err !== (err_exp && !we) || store_err !== (err_exp && we))
          flag_error($sformatf("error flags %b/%b at %h, error expected %b",
                               load_err, store_err, addr, err_exp));
        if (rdata_valid !== (!we && !err_exp)) flag_error("rdata_valid_o wrong");
        if (!we && !err_exp && rdata !== exp_val)
          flag_error($sformatf("load %h size %0d: got %h, expected %h", addr, n, rdata, exp_val));
        if (err_exp && addr_last !== last_exp)
          flag_error($sformatf("addr_last_o %h, expected %h", addr_last, last_exp));
      end
      bus_sample();
    end
    n_acc = n_acc + 1;
    if (!resp_seen) begin
      errors = errors + 1;
      $display("access to %h got no response within 100 cycles", addr);
    end
    if (n_gnt != (pmp ? 0 : split ? 2 : 1) || n_done != 1) begin
      flag_error($sformatf("access %h: %0d grants, %0d done pulses", addr, n_gnt, n_done));
    end else if (!pmp) begin
      if (be_log[0] !== mask[3:0] || baddr_log[0] !== {addr[31:2], 2'b00})
        flag_error($sformatf("first part of %h: be %b at %h", addr, be_log[0], baddr_log[0]));
      if (split && (be_log[1] !== mask[7:4] || baddr_log[1] !== {addr[31:2] + 30'd1, 2'b00}))
        flag_error($sformatf("second part of %h: be %b at %h", addr, be_log[1], baddr_log[1]));
    end
    mism = 0;
    for (i = 0; i < 256; i++) begin
      if (mem[i] !== ref_mem[i]) mism = mism + 1;
    end
    if (mism != 0) flag_error($sformatf("%0d memory bytes differ after access %h", mism, addr));
  endtask

  ////////////////////////////////////////////////////////////
  // sequence
  ////////////////////////////////////////////////////////////

  initial begin
    seed     = 27088;
    errors   = 0;
    n_acc    = 0;
    pmp_word = '0; // outside the window
    for (k = 0; k < 256; k++) begin
      mem[k]     = k * 13 + (k >> 3);
      ref_mem[k] = mem[k];
    end
    for (k = 0; k < 64; k++) err_word[k] = 1'b0;
    rst_ni   = 1'b0;
    lsu_req  = 1'b0;
    req_data = '0;
    bus_rsp  = '0;
    pmp_err  = 1'b0;
    gnt_wait = 0;
    rv_next  = 1'b0;
    err_next = 1'b0;
    rd_next  = '0;
    waited   = 1'b0;
    repeat (3) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    mark = errors;
    for (k = 0; k < N_RAND; k++) begin
      r = $random(seed);
      run_access(r[0], r[2:1], r[3], BASE + r[11:4], $random(seed));
    end
    $display("test random accesses: %0d errors", errors - mark);

    mark = errors;
    err_word[16] = 1'b1;                             // word at BASE + 0x40
    run_access(1'b0, 2'b00, 1'b0, BASE + 32'h40, '0);
    run_access(1'b1, 2'b10, 1'b0, BASE + 32'h42, $random(seed));
    run_access(1'b0, 2'b00, 1'b0, BASE + 32'h3d, '0); // second part fails
    run_access(1'b0, 2'b00, 1'b1, BASE + 32'h43, '0); // first part fails
    err_word[16] = 1'b0;
    $display("test bus errors: %0d errors", errors - mark);

    mark = errors;
    pmp_word = (BASE + 32'h80) >> 2;
    run_access(1'b0, 2'b01, 1'b1, BASE + 32'h80, '0);
    pmp_word = (BASE + 32'h84) >> 2;
    run_access(1'b1, 2'b00, 1'b0, BASE + 32'h84, $random(seed));
    pmp_word = '0;
    $display("test pmp errors: %0d errors", errors - mark);

    $display("%0d accesses, %0d errors", n_acc, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(8 * 400 * (N_RAND + N_DIR));
    $display("watchdog expired before all accesses finished");
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+source
source/lsu_pkg.sv
source/lsu_bus_pkg.sv
source/lsu_wdata_align.sv
source/lsu_rdata_align.sv
source/lsu_ctrl_fsm.sv
source/load_store_unit.sv
test/lsu_checker.sv
test/lsu_tb.sv
